//--- fifo_buf.f
design/fifo_pkg.sv
design/mem_if.sv
design/dp_memory.sv
design/fifo_ctrl.sv
design/fifo_sync.sv
sim/fifo_checker.sv
sim/fifo_assert.sv
sim/tb_fifo_sync.sv

//--- Makefile
# Verilator build and run for the fifo_buf project
# run from the project root, the testbench reads sim/fifo_trace.txt from here

TOP := tb_fifo_sync

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): fifo_buf.f design/*.sv sim/*.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f fifo_buf.f

# pass only when the pass line shows up in the output
run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

lint:
	verilator --lint-only -Wall --top-module fifo_sync \
		design/fifo_pkg.sv design/mem_if.sv design/dp_memory.sv \
		design/fifo_ctrl.sv design/fifo_sync.sv

clean:
	rm -rf obj_dir

//--- sim/fifo_trace.txt
# one line per clock cycle, applied 10 ns after the rising edge
# columns: clear wr_en rd_en din (hex), text after the fourth field is ignored
# fill: 17 writes into an empty FIFO, the last one is dropped while full
0 1 0 a0000001
0 1 0 a0000002
0 1 0 a0000003
0 1 0 a0000004
0 1 0 a0000005
0 1 0 a0000006
0 1 0 a0000007
0 1 0 a0000008
0 1 0 a0000009
0 1 0 a000000a
0 1 0 a000000b
0 1 0 a000000c
0 1 0 a000000d
0 1 0 a000000e
0 1 0 a000000f
0 1 0 a0000010
0 1 0 a0000011
# drain: 16 reads in write order, one more while empty
0 0 1 00000000
0 0 1 00000000
0 0 1 00000000
0 0 1 00000000
0 0 1 00000000
0 0 1 00000000
0 0 1 00000000
0 0 1 00000000
0 0 1 00000000
0 0 1 00000000
0 0 1 00000000
0 0 1 00000000
0 0 1 00000000
0 0 1 00000000
0 0 1 00000000
0 0 1 00000000
0 0 1 00000000
# read and write together at 3 entries, the write pointer wraps
0 1 0 b0000001
0 1 0 b0000002
0 1 0 b0000003
0 1 1 b0000004
0 1 1 b0000005
0 1 1 b0000006
0 1 1 b0000007
0 1 1 b0000008
0 1 1 b0000009
0 1 1 b000000a
0 1 1 b000000b
0 1 1 b000000c
0 1 1 b000000d
0 1 1 b000000e
0 1 1 b000000f
0 1 1 b0000010
0 1 1 b0000011
0 0 1 00000000
0 0 1 00000000
0 0 1 00000000
# one write into an empty FIFO, rd_en held after it reads one word
0 1 0 c0000001
0 0 1 00000000
0 0 1 00000000
0 0 1 00000000
0 0 1 00000000
0 0 1 00000000
# clear with entries held, then only the new words read back
0 1 0 d0000001
0 1 0 d0000002
0 1 0 d0000003
1 1 1 d0000004   clear wins over both requests
0 1 0 e0000001
0 1 0 e0000002
0 0 1 00000000
0 0 1 00000000
0 0 1 00000000
0 0 1 00000000

//--- sim/tb_fifo_sync.sv
/*
 * testbench for fifo_sync, every cycle comes from sim/fifo_trace.txt
 * run from the project root; reset is only applied at the start
 */
`timescale 1ns/1ps

module tb_fifo_sync;
   import fifo_pkg::*;

   localparam int CLK_PERIOD   = 100;  // ns
   localparam int DRIVE_DELAY  = 10;   // inputs change this long after the edge
   localparam int FLUSH_CYCLES = 6;    // lets the last reads reach dout
   localparam int SPARE_CYCLES = 30;   // watchdog margin past the trace

   // dut ports
   logic  clk;
   logic  nreset;
   logic  clear;
   logic  wr_en;
   logic  rd_en;
   word_t din;
   word_t dout;
   logic  full;
   logic  almost_full;
   logic  empty;
   cnt_t  rd_count;

   int    err_cnt;          // from the checker
   int    chk_cnt;
   int    trace_len = 0;    // cycles in the trace
   bit    trace_ready;      // trace loaded, watchdog may start

   // one entry per trace cycle
   logic  trc_clear [$];
   logic  trc_wr    [$];
   logic  trc_rd    [$];
   word_t trc_din   [$];

   //############################################################
   // dut and checker
   //############################################################
   fifo_sync dut_i (
      .clk (clk), .nreset (nreset), .clear (clear),
      .din (din), .wr_en (wr_en), .full (full), .almost_full (almost_full),
      .rd_en (rd_en), .dout (dout), .empty (empty), .rd_count (rd_count)
   );

   fifo_checker chk_i (
      .clk (clk), .nreset (nreset), .clear (clear),
      .wr_en (wr_en), .rd_en (rd_en), .din (din),
      .full (full), .almost_full (almost_full), .empty (empty),
      .rd_count (rd_count), .dout (dout),
      .err_cnt (err_cnt), .chk_cnt (chk_cnt)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   // returns cycles read, -1 if the file is missing
   function automatic int load_trace();
      int          fd;
      int          got;
      string       line;
      logic [31:0] f_clr;
      logic [31:0] f_wr;
      logic [31:0] f_rd;
      word_t       f_din;
      fd = $fopen("sim/fifo_trace.txt", "r");
      if (fd == 0)
      begin
         return -1;
      end
      while (!$feof(fd))
      begin
         line = "";
         got  = $fgets(line, fd);
         // comment and blank lines do not give four fields
         if (got > 0 && $sscanf(line, "%h %h %h %h", f_clr, f_wr, f_rd, f_din) == 4)
         begin
            trc_clear.push_back(f_clr[0]);
            trc_wr.push_back(f_wr[0]);
            trc_rd.push_back(f_rd[0]);
            trc_din.push_back(f_din);
         end
      end
      $fclose(fd);
      return trc_din.size();
   endfunction

   task automatic drive_line(input int idx);
      clear = trc_clear[idx];
      wr_en = trc_wr[idx];
      rd_en = trc_rd[idx];
      din   = trc_din[idx];
   endtask

   //############################################################
   // main sequence
   //############################################################
   initial
   begin
      int n_lines;
      int fails;
      $timeformat(-9, 0, " ns", 0);
      nreset = 1'b0;
      clear  = 1'b0;
      wr_en  = 1'b0;
      rd_en  = 1'b0;
      din    = '0;
      n_lines = load_trace();
      if (n_lines <= 0)
      begin
         $display("trace file sim/fifo_trace.txt is missing or holds no cycles");
         $display("tests failed");
         $finish;
      end
      else
      begin
         trace_len   = n_lines;
         trace_ready = 1'b1;
         repeat (3) @(posedge clk);  // 3 cycles in reset
         #(DRIVE_DELAY);
         nreset = 1'b1;
         for (int i = 0; i < n_lines; i++)
         begin
            drive_line(i);
            @(posedge clk);
            #(DRIVE_DELAY);
         end
         clear = 1'b0;  // idle while reads drain to dout
         wr_en = 1'b0;
         rd_en = 1'b0;
         repeat (FLUSH_CYCLES) @(posedge clk);
         #(DRIVE_DELAY);
         fails = err_cnt + dut_i.u_ctrl.u_fifo_assert.fail_cnt;
         $display("checks %0d, checker errors %0d, assertion failures %0d",
                  chk_cnt, err_cnt, dut_i.u_ctrl.u_fifo_assert.fail_cnt);
         if (fails == 0)
         begin
            $display("all tests passed");
         end
         else
         begin
            $display("tests failed");
         end
         $finish;
      end
   end

   // watchdog, trace length plus margin
   initial
   begin
      wait (trace_ready);
      #(CLK_PERIOD * (trace_len + SPARE_CYCLES));
      $display("timeout: run did not end within %0d cycles", trace_len + SPARE_CYCLES);
      $display("tests failed");
      $finish;
   end

endmodule

//--- sim/fifo_assert.sv
/*
 * assertions on fifo_ctrl, bound by module name into every instance
 * relies on the internal accept strobes wr_accept and rd_accept
 */
`timescale 1ns/1ps

module fifo_assert (
   input logic           clk,
   input logic           nreset,
   input logic           clear,
   input logic           full,
   input logic           empty,
   input logic           wr_accept,  // write taken this edge
   input logic           rd_accept,  // read taken this edge
   input fifo_pkg::cnt_t rd_count
);
   import fifo_pkg::*;

   int fail_cnt = 0;  // failed assertions so far

   // flags exclusive
   a_full_empty: assert property (@(posedge clk) disable iff (!nreset) !(full && empty))
   else
   begin
      $error("full and empty high together");
      fail_cnt++;
   end

   a_count_max: assert property (@(posedge clk) disable iff (!nreset)
                                 rd_count <= cnt_t'(DEPTH))
   else
   begin
      $error("rd_count above DEPTH");
      fail_cnt++;
   end

   // write alone grows the count by one
   a_write_count: assert property (@(posedge clk) disable iff (!nreset)
                                   (wr_accept && !rd_accept)
                                   |=> (rd_count == $past(rd_count) + 1'b1))
   else
   begin
      $error("accepted write did not raise rd_count");
      fail_cnt++;
   end

   a_clear_count: assert property (@(posedge clk) disable iff (!nreset)
                                   clear |=> (rd_count == '0))
   else
   begin
      $error("rd_count not 0 after clear");
      fail_cnt++;
   end

endmodule

bind fifo_ctrl fifo_assert u_fifo_assert (
   .clk       (clk),
   .nreset    (nreset),
   .clear     (clear),
   .full      (full),
   .empty     (empty),
   .wr_accept (wr_accept),
   .rd_accept (rd_accept),
   .rd_count  (rd_count)
);

//--- sim/fifo_checker.sv
/*
 * FIFO reference model built only from the port activity of fifo_sync
 * inputs must change away from the rising edge, outputs are taken pre-edge
 */
`timescale 1ns/1ps

module fifo_checker (
   input  logic            clk,          // clock
   input  logic            nreset,       // async reset, active low
   input  logic            clear,        // sync clear
   input  logic            wr_en,        // write request
   input  logic            rd_en,        // read request
   input  fifo_pkg::word_t din,          // write data
   input  logic            full,         // dut flags
   input  logic            almost_full,
   input  logic            empty,
   input  fifo_pkg::cnt_t  rd_count,     // dut occupancy
   input  fifo_pkg::word_t dout,         // dut read data
   output int              err_cnt,      // mismatches seen
   output int              chk_cnt       // comparisons made
);
   import fifo_pkg::*;

   //############################################################
   // model state
   //############################################################
   word_t held_q   [$];  // words in the FIFO, oldest first
   word_t flight_q [$];  // words read, not yet on dout
   int    due_q    [$];  // edge at which each shows up
   word_t dout_exp;      // dout holds between reads
   int    count;         // entries in the model
   int    edge_cnt = 0;  // rising edges seen
   logic  was_zero;      // count was 0 last cycle
   logic  exp_full;
   logic  exp_empty;
   logic  wr_take;       // write accepted by the rules
   logic  rd_take;       // read accepted by the rules
   int    errors = 0;
   int    checks = 0;

   assign err_cnt = errors;
   assign chk_cnt = checks;

   task automatic compare(input string field, input word_t exp_v, input word_t got_v);
      checks++;
      if (got_v !== exp_v)
      begin
         errors++;
         $display("FAIL %0t: %s expected %0h, got %0h", $time, field, exp_v, got_v);
      end
   endtask

   //############################################################
   // per-edge compare and update
   //############################################################
   always @(posedge clk)
   begin
      if (!nreset)
      begin
         // values forced by the async reset
         compare("rd_count", '0, word_t'(rd_count));
         compare("full", '0, word_t'(full));
         compare("almost_full", '0, word_t'(almost_full));
         compare("empty", word_t'(1'b1), word_t'(empty));
         compare("dout", '0, dout);
         held_q.delete();
         flight_q.delete();
         due_q.delete();
         dout_exp = '0;
         count    = 0;
         was_zero = 1'b1;  // empty starts stretched
      end
      else
      begin
         exp_full  = (count == DEPTH);
         exp_empty = (count == 0) || (MEM_REG == 1 && was_zero);  // late fall
         compare("rd_count", word_t'(count), word_t'(rd_count));
         compare("full", word_t'(exp_full), word_t'(full));
         compare("almost_full", word_t'(count >= PROGFULL), word_t'(almost_full));
         compare("empty", word_t'(exp_empty), word_t'(empty));

         // on dout MEM_REG edges after the read edge, seen pre-edge one later
         if (due_q.size() > 0 && due_q[0] == edge_cnt)
         begin
            dout_exp = flight_q.pop_front();
            void'(due_q.pop_front());
         end
         compare("dout", dout_exp, dout);

         wr_take  = wr_en && !exp_full && !clear;   // dropped when full
         rd_take  = rd_en && !exp_empty && !clear;  // dropped when empty
         was_zero = (count == 0);
         if (clear)
         begin
            held_q.delete();  // reads already in flight still land
         end
         else
         begin
            if (rd_take)
            begin
               flight_q.push_back(held_q.pop_front());
               due_q.push_back(edge_cnt + MEM_REG + 1);
            end
            if (wr_take)
            begin
               held_q.push_back(din);
            end
         end
         count = held_q.size();
      end
      edge_cnt++;
   end

endmodule

//--- design/fifo_sync.sv
/*
 * synchronous FIFO, fifo_pkg::DEPTH words of fifo_pkg::DW bits
 * dout trails an accepted read by fifo_pkg::MEM_REG+1 edges
 */
`timescale 1ns/1ps

module fifo_sync (
   // common
   input  logic            clk,          // clock
   input  logic            nreset,       // async reset, active low
   input  logic            clear,        // sync clear

   // write side
   input  fifo_pkg::word_t din,          // write data
   input  logic            wr_en,        // write request
   output logic            full,         // writes dropped while high
   output logic            almost_full,  // PROGFULL reached

   // read side
   input  logic            rd_en,        // read request
   output fifo_pkg::word_t dout,         // read data, held between reads
   output logic            empty,        // reads dropped while high
   output fifo_pkg::cnt_t  rd_count      // entries held
);
   import fifo_pkg::*;

   //############################################################
   // controller to array
   //############################################################
   mem_if #(.payload_t(word_t)) mem_bus ();

   assign mem_bus.wr_din = din;      // data rides alongside the strobe
   assign dout = mem_bus.rd_dout;

   //############################################################
   // blocks
   //############################################################

   // pointers and flags
   fifo_ctrl u_ctrl (
      .clk         (clk),
      .nreset      (nreset),
      .clear       (clear),
      .wr_en       (wr_en),
      .rd_en       (rd_en),
      .full        (full),
      .almost_full (almost_full),
      .empty       (empty),
      .rd_count    (rd_count),
      .mem         (mem_bus)
   );

   // storage
   dp_memory #(
      .payload_t (word_t)
   ) u_mem (
      .clk    (clk),
      .nreset (nreset),
      .mem    (mem_bus)
   );

endmodule

//--- design/fifo_ctrl.sv
/*
 * FIFO pointers, count and flags; clear is synchronous and wins over access
 * requests refused by full or empty are dropped without notice
 */
`timescale 1ns/1ps

module fifo_ctrl (
   input  logic           clk,          // clock
   input  logic           nreset,       // async reset, active low
   input  logic           clear,        // sync clear, empties the FIFO
   input  logic           wr_en,        // write request
   input  logic           rd_en,        // read request
   output logic           full,         // DEPTH entries held
   output logic           almost_full,  // at or above PROGFULL
   output logic           empty,        // nothing readable
   output fifo_pkg::cnt_t rd_count,     // entries held, 0..DEPTH
   mem_if.ctrl            mem           // array strobes and addresses
);
   import fifo_pkg::*;

   //############################################################
   // local signals
   //############################################################
   logic [AW:0] wr_ptr;     // write pointer, msb is the wrap bit
   logic [AW:0] rd_ptr;     // read pointer, msb is the wrap bit
   logic        ptr_match;  // addresses equal
   logic        raw_empty;  // pointers equal, wraps equal
   logic        empty_q;    // raw_empty one edge ago
   logic        wr_accept;  // write taken at this edge
   logic        rd_accept;  // read taken at this edge

   //############################################################
   // acceptance
   //############################################################

   // clear drops both sides
   assign wr_accept = wr_en & ~full & ~clear;
   assign rd_accept = rd_en & ~empty & ~clear;

   // strobes go straight to the array
   assign mem.wr_en   = wr_accept;
   assign mem.wr_addr = wr_ptr[AW-1:0];
   assign mem.rd_en   = rd_accept;
   assign mem.rd_addr = rd_ptr[AW-1:0];

   //############################################################
   // flags
   //############################################################
   assign ptr_match = (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
   assign full      = ptr_match & (wr_ptr[AW] != rd_ptr[AW]);  // writer a lap ahead
   assign raw_empty = ptr_match & (wr_ptr[AW] == rd_ptr[AW]);

   assign almost_full = (rd_count >= cnt_t'(PROGFULL));

   // empty rises with raw_empty but falls a cycle late
   // gives a first write time to reach the registered read path
   assign empty = (MEM_REG == 1) ? (raw_empty | empty_q) : raw_empty;

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         empty_q <= 1'b1;
      end
      else
      begin
         empty_q <= raw_empty;
      end
   end

   //############################################################
   // pointers
   //############################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else if (clear)
      begin
         wr_ptr <= '0;  // back to the empty state
         rd_ptr <= '0;
      end
      else
      begin
         if (wr_accept)
         begin
            wr_ptr <= wr_ptr + 1'b1;  // wraps into msb
         end
         if (rd_accept)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   //############################################################
   // occupancy
   //############################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         rd_count <= '0;
      end
      else if (clear)
      begin
         rd_count <= '0;
      end
      else
      begin
         case ({wr_accept, rd_accept})
            2'b10:   rd_count <= rd_count + 1'b1;  // write only
            2'b01:   rd_count <= rd_count - 1'b1;  // read only
            default: rd_count <= rd_count;         // both or none
         endcase
      end
   end

endmodule

//--- design/dp_memory.sv
/*
 * dual-port array, one clock, read latency 1 or 2 per fifo_pkg::MEM_REG
 * array contents are undefined after reset, only the read registers clear
 */
`timescale 1ns/1ps

module dp_memory #(
   parameter type payload_t = fifo_pkg::word_t  // stored word type
) (
   input  logic clk,     // clock
   input  logic nreset,  // async reset, read registers only
   mem_if.mem   mem      // write and read ports
);
   import fifo_pkg::*;

   //############################################################
   // storage
   //############################################################
   payload_t ram [DEPTH];  // no reset on the array
   payload_t rd_q;         // first read stage

   // whole-word writes, no masks
   always_ff @(posedge clk)
   begin
      if (mem.wr_en)
      begin
         ram[mem.wr_addr] <= mem.wr_din;
      end
   end

   //############################################################
   // read path
   //############################################################

   // registered read, loads only on a strobe
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         rd_q <= '0;
      end
      else if (mem.rd_en)
      begin
         rd_q <= ram[mem.rd_addr];  // same-edge write not visible here
      end
   end

   generate
      if (MEM_REG == 1)
      begin : g_out_reg
         logic     rd_pend;  // read done last edge, stage two follows
         payload_t out_q;    // second read stage

         always_ff @(posedge clk or negedge nreset)
         begin
            if (!nreset)
            begin
               rd_pend <= 1'b0;
               out_q   <= '0;
            end
            else
            begin
               rd_pend <= mem.rd_en;
               if (rd_pend)
               begin
                  out_q <= rd_q;  // follows stage one by a cycle
               end
            end
         end

         assign mem.rd_dout = out_q;
      end
      else
      begin : g_no_out_reg
         assign mem.rd_dout = rd_q;  // single stage latency
      end
   endgenerate

endmodule

//--- design/mem_if.sv
/*
 * storage array ports, write and read on the same clock
 * strobes are single cycle, no handshake
 */
`timescale 1ns/1ps

interface mem_if #(
   parameter type payload_t = fifo_pkg::word_t  // word carried on the data lines
);
   import fifo_pkg::*;

   // write port
   logic     wr_en;    // write at this edge
   addr_t    wr_addr;  // write location
   payload_t wr_din;   // write data, driven from the top level

   // read port
   logic     rd_en;    // read at this edge
   addr_t    rd_addr;  // read location
   payload_t rd_dout;  // read data, held between reads

   // pointer side issues strobes and addresses
   modport ctrl (
      output wr_en, wr_addr,
      output rd_en, rd_addr
   );

   // array side
   modport mem (
      input  wr_en, wr_addr, wr_din,
      input  rd_en, rd_addr,
      output rd_dout
   );

endinterface

//--- design/fifo_pkg.sv
/*
 * sizes and types shared by the FIFO blocks
 * DEPTH must be a power of two, the pointer wrap bit relies on it
 */
package fifo_pkg;

   //############################################################
   // sizes
   //############################################################
   localparam int DW       = 32;             // payload width
   localparam int DEPTH    = 16;             // entries, power of two
   localparam int AW       = $clog2(DEPTH);  // array address width
   localparam int PROGFULL = DEPTH - 1;      // almost_full threshold

   // 1 adds a second register behind the array read
   // one extra cycle of read latency, empty stretched to match
   localparam int MEM_REG  = 1;

   //############################################################
   // types
   //############################################################

   // one payload word
   typedef logic [DW-1:0] word_t;

   // array address, no wrap bit
   typedef logic [AW-1:0] addr_t;

   // occupancy, one bit wider so a full FIFO reads DEPTH
   typedef logic [AW:0] cnt_t;

endpackage
